// ==== src.f ====
+incdir+hw
hw/qdr_pkg.sv
hw/qdr_delay_line.sv
hw/qdr_cal_timer.sv
hw/qdr_cal_fsm.sv
hw/qdr_phy.sv
hw/qdr_ctrl_top.sv
tests/qdr_sram_model.sv
tests/tb_qdr_ctrl.sv

// ==== Bender.yml ====
package:
  name: qdr_ctrl

export_include_dirs:
  - hw

sources:
  - files:
      - hw/qdr_pkg.sv
      - hw/qdr_delay_line.sv
      - hw/qdr_cal_timer.sv
      - hw/qdr_cal_fsm.sv
      - hw/qdr_phy.sv
      - hw/qdr_ctrl_top.sv
  - target: test
    files:
      - tests/qdr_sram_model.sv
      - tests/tb_qdr_ctrl.sv

// ==== tests/tb_qdr_ctrl.sv ====
`include "qdr_config.svh"

module tb_qdr_ctrl;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_OPS      = 300;
  localparam int MAX_GAP      = 4;
  // an attempt is bounded by write, gap, read and the read timeout.
  localparam int CAL_CYCLES   = `QDR_DLL_CYCLES + `QDR_CAL_TRIES * (4 + `QDR_CAL_TIMEOUT);
  localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + CAL_CYCLES) +
                                (NUM_OPS + 40) * (1 + MAX_GAP) + 200;

  logic           clk0 = 1'b0;
  logic           reset;
  logic           usr_rd_strb;
  logic           usr_wr_strb;
  qdr_pkg::addr_t usr_addr;
  qdr_pkg::word_t usr_wr_data;
  qdr_pkg::word_t usr_rd_data;
  logic           usr_rd_dvld;
  logic           phy_rdy;
  logic           cal_fail;
  qdr_pkg::beat_t qdr_d;
  qdr_pkg::beat_t qdr_q;
  qdr_pkg::addr_t qdr_sa;
  logic           qdr_w_n;
  logic           qdr_r_n;
  logic           qdr_dll_off_n;
  logic           fault;

  qdr_pkg::word_t ref_mem [2**`QDR_ADDR_WIDTH];
  qdr_pkg::addr_t written_q [$];  // addresses that hold a known word.
  int             due_q [$];      // cycle in which each read word is expected.
  qdr_pkg::word_t data_q [$];
  string          name_q [$];

  logic [31:0]    lfsr_state = 32'h3e29_63c7;
  int             cyc = 0;
  int             dll_low = 0;
  logic           dll_checked = 1'b0;
  int             cal_cmds = 0;

  always #2 clk0 = ~clk0;

  qdr_ctrl_top u_qdr_ctrl_top (
    .clk0          (clk0),
    .reset         (reset),
    .usr_rd_strb   (usr_rd_strb),
    .usr_wr_strb   (usr_wr_strb),
    .usr_addr      (usr_addr),
    .usr_wr_data   (usr_wr_data),
    .usr_rd_data   (usr_rd_data),
    .usr_rd_dvld   (usr_rd_dvld),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .qdr_d         (qdr_d),
    .qdr_q         (qdr_q),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_dll_off_n (qdr_dll_off_n)
  );

  qdr_sram_model u_sram (
    .clk0    (clk0),
    .fault   (fault),
    .qdr_sa  (qdr_sa),
    .qdr_w_n (qdr_w_n),
    .qdr_r_n (qdr_r_n),
    .qdr_d   (qdr_d),
    .qdr_q   (qdr_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random numbers and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic qdr_pkg::word_t random_word();
    return qdr_pkg::word_t'(take_bits(2 * `QDR_DATA_WIDTH));
  endfunction

  function automatic qdr_pkg::addr_t pick_written();
    int idx;
    idx = int'(take_bits(16)) % written_q.size();
    return written_q[idx];
  endfunction

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error.");
  endtask

  task automatic check_value(input string test, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                test, expected, actual));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk0);
  endtask

  task automatic drive_strobe(input logic is_read, input qdr_pkg::addr_t addr,
                              input qdr_pkg::word_t data);
    usr_rd_strb <= is_read;
    usr_wr_strb <= !is_read;
    usr_addr    <= addr;
    usr_wr_data <= data;
    @(posedge clk0);
    usr_rd_strb <= 1'b0;  // strobes last a single cycle.
    usr_wr_strb <= 1'b0;
  endtask

  task automatic do_write(input qdr_pkg::addr_t addr, input qdr_pkg::word_t data);
    ref_mem[addr] = data;
    written_q.push_back(addr);
    drive_strobe(1'b0, addr, data);
  endtask

  task automatic do_read(input string test, input qdr_pkg::addr_t addr);
    due_q.push_back(cyc + 1 + `QDR_RD_LATENCY);  // the DUT samples the strobe next edge.
    data_q.push_back(ref_mem[addr]);
    name_q.push_back(test);
    drive_strobe(1'b1, addr, '0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor, sampled on the rising edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk0) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      stop_on_failure($sformatf("Timeout: the run did not end within %0d cycles.", MAX_CYCLES));
    end
    if (reset) begin
      dll_low     <= 0;
      dll_checked <= 1'b0;
      cal_cmds    <= 0;
    end else begin
      if (!qdr_dll_off_n) begin
        dll_low <= dll_low + 1;
      end else if (!dll_checked) begin
        check_value("dll wait", 64'(`QDR_DLL_CYCLES), 64'(dll_low));
        dll_checked <= 1'b1;
      end
      // until phy_rdy only the calibration commands at address 0 reach the pins.
      if (!phy_rdy && (!qdr_w_n || !qdr_r_n)) begin
        check_value("calibration address", 64'd0, 64'(qdr_sa));
        cal_cmds <= cal_cmds + 1;
      end
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        check_value({name_q[0], " valid"}, 64'd1, 64'(usr_rd_dvld));
        check_value(name_q[0], 64'(data_q[0]), 64'(usr_rd_data));
        due_q.delete(0);
        data_q.delete(0);
        name_q.delete(0);
      end else if (phy_rdy && usr_rd_dvld) begin
        stop_on_failure("usr_rd_dvld went high with no read due in that cycle.");
      end
    end
  end

  initial begin
    qdr_pkg::addr_t addr;
    qdr_pkg::word_t data;

    reset       = 1'b1;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    fault       = 1'b0;
    idle(RESET_CYCLES);
    reset <= 1'b0;

    // strobes during the DLL wait are dropped by the PHY.
    while (!qdr_dll_off_n) begin
      addr = qdr_pkg::addr_t'(take_bits(`QDR_ADDR_WIDTH));
      if (addr == '0) begin
        addr = 1;
      end
      drive_strobe(take_bits(1) == 64'd1, addr, random_word());
      idle(1 + int'(take_bits(2)));
    end

    while (!phy_rdy && !cal_fail) begin
      @(posedge clk0);
    end
    check_value("phy_rdy after calibration", 64'd1, 64'(phy_rdy));
    check_value("cal_fail after calibration", 64'd0, 64'(cal_fail));
    check_value("calibration commands", 64'd2, 64'(cal_cmds));
    ref_mem[0] = `QDR_CAL_PATTERN;
    written_q.push_back('0);

    addr = qdr_pkg::addr_t'(take_bits(`QDR_ADDR_WIDTH));
    data = random_word();
    do_write(addr, data);
    idle(1);
    do_read("write then read", addr);
    idle(1);

    // reads spaced by one idle cycle keep several in flight.
    for (int i = 0; i < 8; i++) begin
      do_read("back to back reads", written_q[i % written_q.size()]);
      idle(1);
    end

    for (int i = 0; i < NUM_OPS; i++) begin
      if (take_bits(1) == 64'd1) begin
        do_read("random traffic", pick_written());
      end else begin
        do_write(qdr_pkg::addr_t'(take_bits(`QDR_ADDR_WIDTH)), random_word());
      end
      idle(1 + int'(take_bits(2)));
    end
    while (due_q.size() != 0) begin
      @(posedge clk0);
    end
    check_value("cal_fail after traffic", 64'd0, 64'(cal_fail));

    // second reset against a memory that corrupts every read.
    fault <= 1'b1;
    reset <= 1'b1;
    idle(RESET_CYCLES);
    reset <= 1'b0;
    while (!phy_rdy && !cal_fail) begin
      @(posedge clk0);
    end
    check_value("cal_fail with a faulty memory", 64'd1, 64'(cal_fail));
    check_value("phy_rdy with a faulty memory", 64'd0, 64'(phy_rdy));
    check_value("calibration commands with a faulty memory",
                64'(2 * `QDR_CAL_TRIES), 64'(cal_cmds));
    idle(20);
    check_value("phy_rdy after cal_fail", 64'd0, 64'(phy_rdy));

    $display("Test OK");
    $finish;
  end

endmodule

// ==== tests/qdr_sram_model.sv ====
`include "qdr_config.svh"

module qdr_sram_model (
  input  logic           clk0,
  input  logic           fault,
  input  qdr_pkg::addr_t qdr_sa,
  input  logic           qdr_w_n,
  input  logic           qdr_r_n,
  input  qdr_pkg::beat_t qdr_d,
  output qdr_pkg::beat_t qdr_q
);

  timeunit 1ns;
  timeprecision 1ps;

  // the first returned beat goes out on the edge after these stages.
  localparam int STAGES = `QDR_SRAM_LATENCY - 1;

  qdr_pkg::word_t             mem [2**`QDR_ADDR_WIDTH];
  logic                       wr_pend = 1'b0;
  qdr_pkg::addr_t             wr_addr;
  qdr_pkg::beat_t             wr_lo;
  logic [STAGES-1:0]          rd_vld = '0;
  qdr_pkg::addr_t             rd_addr [STAGES];
  logic                       hi_pend = 1'b0;
  qdr_pkg::beat_t             hi_hold;
  qdr_pkg::beat_t             q_reg = '0;
  qdr_pkg::beat_t             flip;

  assign flip  = {`QDR_DATA_WIDTH{fault}};  // a faulty part returns every bit inverted.
  assign qdr_q = q_reg;

  always @(posedge clk0) begin
    // the high beat of a write arrives one cycle after its command.
    if (wr_pend) begin
      mem[wr_addr] <= {qdr_d, wr_lo};
    end
    wr_pend <= !qdr_w_n;
    wr_addr <= qdr_sa;
    wr_lo   <= qdr_d;

    rd_vld[0]  <= !qdr_r_n;
    rd_addr[0] <= qdr_sa;
    for (int i = 1; i < STAGES; i++) begin
      rd_vld[i]  <= rd_vld[i-1];
      rd_addr[i] <= rd_addr[i-1];
    end

    if (rd_vld[STAGES-1]) begin
      q_reg   <= mem[rd_addr[STAGES-1]][`QDR_DATA_WIDTH-1:0] ^ flip;  // rise beat first.
      hi_hold <= mem[rd_addr[STAGES-1]][2*`QDR_DATA_WIDTH-1:`QDR_DATA_WIDTH];
      hi_pend <= 1'b1;
    end else begin
      q_reg   <= hi_pend ? (hi_hold ^ flip) : '0;
      hi_pend <= 1'b0;
    end
  end

endmodule

// ==== hw/qdr_ctrl_top.sv ====
`include "qdr_config.svh"

module qdr_ctrl_top (
  input  logic           clk0,
  input  logic           reset,
  input  logic           usr_rd_strb,
  input  logic           usr_wr_strb,
  input  qdr_pkg::addr_t usr_addr,
  input  qdr_pkg::word_t usr_wr_data,
  output qdr_pkg::word_t usr_rd_data,
  output logic           usr_rd_dvld,
  output logic           phy_rdy,
  output logic           cal_fail,
  output qdr_pkg::beat_t qdr_d,
  input  qdr_pkg::beat_t qdr_q,
  output qdr_pkg::addr_t qdr_sa,
  output logic           qdr_w_n,
  output logic           qdr_r_n,
  output logic           qdr_dll_off_n
);

  logic                        timer_load;
  logic [`QDR_TIMER_WIDTH-1:0] timer_value;
  logic                        timer_done;
  logic                        cal_active;
  logic                        cal_wr_strb;
  logic                        cal_rd_strb;
  qdr_pkg::addr_t              cal_addr;
  qdr_pkg::word_t              cal_wr_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // calibration.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  qdr_cal_timer u_cal_timer (
    .clk0        (clk0),
    .reset       (reset),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .timer_done  (timer_done)
  );

  // the FSM watches the same read path the user sees.
  qdr_cal_fsm u_cal_fsm (
    .clk0        (clk0),
    .reset       (reset),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .timer_done  (timer_done),
    .cal_active  (cal_active),
    .cal_wr_strb (cal_wr_strb),
    .cal_rd_strb (cal_rd_strb),
    .cal_addr    (cal_addr),
    .cal_wr_data (cal_wr_data),
    .rd_dvld     (usr_rd_dvld),
    .rd_data     (usr_rd_data),
    .dll_off_n   (qdr_dll_off_n),
    .phy_rdy     (phy_rdy),
    .cal_fail    (cal_fail)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PHY.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  qdr_phy u_phy (
    .clk0        (clk0),
    .reset       (reset),
    .phy_rdy     (phy_rdy),
    .cal_active  (cal_active),
    .cal_rd_strb (cal_rd_strb),
    .cal_wr_strb (cal_wr_strb),
    .cal_addr    (cal_addr),
    .cal_wr_data (cal_wr_data),
    .usr_rd_strb (usr_rd_strb),
    .usr_wr_strb (usr_wr_strb),
    .usr_addr    (usr_addr),
    .usr_wr_data (usr_wr_data),
    .rd_data     (usr_rd_data),
    .rd_dvld     (usr_rd_dvld),
    .qdr_d       (qdr_d),
    .qdr_q       (qdr_q),
    .qdr_sa      (qdr_sa),
    .qdr_w_n     (qdr_w_n),
    .qdr_r_n     (qdr_r_n)
  );

endmodule

// ==== hw/qdr_phy.sv ====
`include "qdr_config.svh"

module qdr_phy (
  input  logic           clk0,
  input  logic           reset,
  input  logic           phy_rdy,
  input  logic           cal_active,
  input  logic           cal_rd_strb,
  input  logic           cal_wr_strb,
  input  qdr_pkg::addr_t cal_addr,
  input  qdr_pkg::word_t cal_wr_data,
  input  logic           usr_rd_strb,
  input  logic           usr_wr_strb,
  input  qdr_pkg::addr_t usr_addr,
  input  qdr_pkg::word_t usr_wr_data,
  output qdr_pkg::word_t rd_data,
  output logic           rd_dvld,
  output qdr_pkg::beat_t qdr_d,
  input  qdr_pkg::beat_t qdr_q,
  output qdr_pkg::addr_t qdr_sa,
  output logic           qdr_w_n,
  output logic           qdr_r_n
);

  // output register, memory latency, then two capture cycles.
  localparam int RD_PIPE = 1 + `QDR_SRAM_LATENCY + 2;

  if (RD_PIPE != `QDR_RD_LATENCY) begin : g_latency_check
    $error("QDR_RD_LATENCY does not match the read pipeline.");
  end

  logic           sel_rd;
  logic           sel_wr;
  qdr_pkg::addr_t sel_addr;
  qdr_pkg::word_t sel_data;
  qdr_pkg::beat_t wr_lo;
  qdr_pkg::beat_t wr_hi;
  qdr_pkg::beat_t hi_in;
  qdr_pkg::beat_t hi_beat;
  qdr_pkg::beat_t q_cap;
  qdr_pkg::beat_t q_lo;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (cal_active) begin
      sel_rd   = cal_rd_strb;
      sel_wr   = cal_wr_strb;
      sel_addr = cal_addr;
      sel_data = cal_wr_data;
    end else begin
      sel_rd   = usr_rd_strb && phy_rdy;  // user traffic only once calibrated.
      sel_wr   = usr_wr_strb && phy_rdy;
      sel_addr = usr_addr;
      sel_data = usr_wr_data;
    end
  end

  assign wr_lo = sel_data[`QDR_DATA_WIDTH-1:0];
  assign wr_hi = sel_data[2*`QDR_DATA_WIDTH-1:`QDR_DATA_WIDTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pin registers and write serialization.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk0) begin
    if (reset) begin
      qdr_w_n <= 1'b1;
      qdr_r_n <= 1'b1;
    end else begin
      qdr_w_n <= !sel_wr;
      qdr_r_n <= !sel_rd;
    end
  end

  // the high beat waits one stage so it lands on qdr_d right after the low one.
  assign hi_in = sel_wr ? wr_hi : '0;

  qdr_delay_line #(
    .T     (qdr_pkg::beat_t),
    .DEPTH (1)
  ) u_wr_hi_dly (
    .clk0  (clk0),
    .reset (reset),
    .din   (hi_in),
    .dout  (hi_beat)
  );

  always_ff @(posedge clk0) begin
    if (sel_rd || sel_wr) begin
      qdr_sa <= sel_addr;
    end
    qdr_d <= sel_wr ? wr_lo : hi_beat;  // no strobe follows a write, so hi_beat is next.
    q_cap <= qdr_q;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read capture and valid.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the low beat is held one more cycle so both halves line up.
  qdr_delay_line #(
    .T     (qdr_pkg::beat_t),
    .DEPTH (1)
  ) u_rd_lo_dly (
    .clk0  (clk0),
    .reset (reset),
    .din   (q_cap),
    .dout  (q_lo)
  );

  qdr_delay_line #(
    .T     (logic),
    .DEPTH (`QDR_RD_LATENCY)
  ) u_rd_vld_dly (
    .clk0  (clk0),
    .reset (reset),
    .din   (sel_rd),
    .dout  (rd_dvld)
  );

  assign rd_data = {q_cap, q_lo};

  // a burst owns the data pins for two cycles.
  assert property (@(posedge clk0) disable iff (reset)
    (sel_rd || sel_wr) |-> !(sel_rd && sel_wr) ##1 !(sel_rd || sel_wr))
    else $error("command strobes violate the burst spacing.");

endmodule

// ==== hw/qdr_cal_fsm.sv ====
`include "qdr_config.svh"

module qdr_cal_fsm (
  input  logic                        clk0,
  input  logic                        reset,
  output logic                        timer_load,
  output logic [`QDR_TIMER_WIDTH-1:0] timer_value,
  input  logic                        timer_done,
  output logic                        cal_active,
  output logic                        cal_wr_strb,
  output logic                        cal_rd_strb,
  output qdr_pkg::addr_t              cal_addr,
  output qdr_pkg::word_t              cal_wr_data,
  input  logic                        rd_dvld,
  input  qdr_pkg::word_t              rd_data,
  output logic                        dll_off_n,
  output logic                        phy_rdy,
  output logic                        cal_fail
);

  localparam int TRY_W = $clog2(`QDR_CAL_TRIES + 1);
  localparam logic [TRY_W-1:0] LAST_TRY = `QDR_CAL_TRIES - 1;
  localparam logic [`QDR_TIMER_WIDTH-1:0] DLL_LOAD = `QDR_DLL_CYCLES - 1;
  localparam logic [`QDR_TIMER_WIDTH-1:0] READ_LOAD = `QDR_CAL_TIMEOUT;

  qdr_pkg::cal_state_e state;
  qdr_pkg::cal_state_e state_next;
  logic                dll_started;  // timer already loaded for the DLL wait.
  logic                wr_gap;       // idle half of CAL_WRITE.
  logic [TRY_W-1:0]    tries;
  logic                pattern_ok;
  logic                attempt_bad;

  assign pattern_ok = (rd_data == `QDR_CAL_PATTERN);

  // a wrong word or a missing one both use up an attempt.
  assign attempt_bad = (state == qdr_pkg::CAL_WAIT) && (rd_dvld ? !pattern_ok : timer_done);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state sequencing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next = state;
    case (state)
      qdr_pkg::DLL_WAIT: begin
        if (dll_started && timer_done) begin
          state_next = qdr_pkg::CAL_WRITE;
        end
      end
      qdr_pkg::CAL_WRITE: begin
        if (wr_gap) begin
          state_next = qdr_pkg::CAL_READ;
        end
      end
      qdr_pkg::CAL_READ: state_next = qdr_pkg::CAL_WAIT;
      qdr_pkg::CAL_WAIT: begin
        if (rd_dvld && pattern_ok) begin
          state_next = qdr_pkg::READY;
        end else if (attempt_bad) begin
          state_next = (tries == LAST_TRY) ? qdr_pkg::FAIL : qdr_pkg::CAL_WRITE;
        end
      end
      default: state_next = state;  // READY and FAIL hold until reset.
    endcase
  end

  always_ff @(posedge clk0) begin
    if (reset) begin
      state       <= qdr_pkg::DLL_WAIT;
      dll_started <= 1'b0;
      wr_gap      <= 1'b0;
      tries       <= '0;
      phy_rdy     <= 1'b0;
      cal_fail    <= 1'b0;
    end else begin
      state       <= state_next;
      dll_started <= 1'b1;
      wr_gap      <= (state == qdr_pkg::CAL_WRITE) && !wr_gap;
      if (attempt_bad) begin
        tries <= tries + 1'b1;
      end
      // the result flags are set on entry and then stay set.
      if (state_next == qdr_pkg::READY) begin
        phy_rdy <= 1'b1;
      end
      if (state_next == qdr_pkg::FAIL) begin
        cal_fail <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs, all decoded from registered state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the same timer serves the DLL wait and the read timeout.
  assign timer_load  = ((state == qdr_pkg::DLL_WAIT) && !dll_started) ||
                       (state == qdr_pkg::CAL_READ);
  assign timer_value = (state == qdr_pkg::DLL_WAIT) ? DLL_LOAD : READ_LOAD;

  assign cal_wr_strb = (state == qdr_pkg::CAL_WRITE) && !wr_gap;
  assign cal_rd_strb = (state == qdr_pkg::CAL_READ);
  assign cal_addr    = '0;  // the pattern always lives at address 0.
  assign cal_wr_data = `QDR_CAL_PATTERN;

  assign cal_active = (state != qdr_pkg::READY);
  assign dll_off_n  = (state != qdr_pkg::DLL_WAIT);

  // one calibration run ends in READY or in FAIL, never in both.
  assert property (@(posedge clk0) disable iff (reset) !(phy_rdy && cal_fail))
    else $error("phy_rdy and cal_fail both high.");

  // nothing can be in flight while the DLL is still off.
  assert property (@(posedge clk0) disable iff (reset) (state == qdr_pkg::DLL_WAIT) |-> !rd_dvld)
    else $error("read data returned during the DLL wait.");

endmodule

// ==== hw/qdr_cal_timer.sv ====
`include "qdr_config.svh"

module qdr_cal_timer (
  input  logic                        clk0,
  input  logic                        reset,
  input  logic                        timer_load,
  input  logic [`QDR_TIMER_WIDTH-1:0] timer_value,
  output logic                        timer_done
);

  logic [`QDR_TIMER_WIDTH-1:0] count;
  logic                        running;

  // the cycle after the load already counts as one, hence the minus one.
  always_ff @(posedge clk0) begin
    if (reset) begin
      count   <= '0;
      running <= 1'b0;
    end else if (timer_load) begin
      count   <= timer_value - 1'b1;
      running <= 1'b1;
    end else if (running) begin
      if (count == '0) begin
        running <= 1'b0;  // done has been shown for its one cycle.
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  assign timer_done = running && (count == '0);

  // a zero load would wrap the counter and never pulse in time.
  assert property (@(posedge clk0) disable iff (reset) timer_load |-> timer_value != '0)
    else $error("timer loaded with zero.");

endmodule

// ==== hw/qdr_delay_line.sv ====
module qdr_delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk0,
  input  logic reset,
  input  T     din,
  output T     dout
);

  // one register per stage, so the latency is exactly DEPTH cycles.
  T stage [DEPTH];

  if (DEPTH < 1) begin : g_depth_check
    $error("qdr_delay_line needs at least one stage.");
  end

  always_ff @(posedge clk0) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];  // shift toward the output.
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

// ==== hw/qdr_pkg.sv ====
`include "qdr_config.svh"

package qdr_pkg;

  // one beat on qdr_d or qdr_q.
  typedef logic [`QDR_DATA_WIDTH-1:0] beat_t;

  // a user word is a full burst. The low half is the rise beat and goes out first.
  typedef logic [2*`QDR_DATA_WIDTH-1:0] word_t;

  typedef logic [`QDR_ADDR_WIDTH-1:0] addr_t;

  // calibration sequence, in the order it normally runs.
  typedef enum logic [2:0] {
    DLL_WAIT,   // memory DLL held off.
    CAL_WRITE,  // pattern write plus one idle cycle.
    CAL_READ,   // single read strobe.
    CAL_WAIT,   // waiting for the read word.
    READY,
    FAIL
  } cal_state_e;

endpackage

// ==== hw/qdr_config.svh ====
`ifndef QDR_CONFIG_SVH
`define QDR_CONFIG_SVH

// memory geometry.
`define QDR_DATA_WIDTH   18   // one beat on the pins.
`define QDR_ADDR_WIDTH   10   // burst address.

// pipeline latencies, in clk0 cycles.
`define QDR_SRAM_LATENCY 2    // read command on the pins to first returned beat.
`define QDR_RD_LATENCY   5    // user read strobe to usr_rd_dvld.

// calibration.
`define QDR_TIMER_WIDTH  16
`define QDR_DLL_CYCLES   64   // qdr_dll_off_n held low this long after reset.
`define QDR_CAL_TRIES    4
`define QDR_CAL_TIMEOUT  16   // read strobe to giving up on rd_dvld.
`define QDR_CAL_PATTERN  36'h5_5556_aaaa

`endif
